//--- Makefile
# Verilator build and run of the correlator front end testbench
VERILATOR ?= verilator
TOP       ?= vis_corr_tb
FILELIST  ?= vis_corr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/vis_config_regs.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

// AXI4-Lite control and status registers
module vis_config_regs (
  input  logic                     clock,
  input  logic                     reset,
  input  vis_pkg::axil_req_t       axil_req_i,
  input  logic                     vis_valid_i,
  output vis_pkg::axil_rsp_t       axil_rsp_o,
  output logic                     enable_o,
  output logic [`VIS_LEN_BITS-1:0] int_len_o
);

  logic                     enable_q;
  logic [`VIS_LEN_BITS-1:0] int_len_q;
  logic [`VIS_LEN_BITS-1:0] len_wr;
  logic [31:0]              count_q;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;
  logic                     rvalid_q;
  logic [31:0]              rdata_q;
  logic [1:0]               rresp_q;
  logic                     wr_accept;
  logic                     rd_accept;
  logic                     wr_ctrl;
  logic                     wr_len;
  logic                     wr_mapped;
  logic [31:0]              rd_data;
  logic                     rd_mapped;

  // Address and data taken together, one response outstanding
  assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign rd_accept = axil_req_i.arvalid & ~rvalid_q;

  // Write decode
  assign wr_ctrl   = wr_accept && (axil_req_i.awaddr == `VIS_ADDR_CTRL);
  assign wr_len    = wr_accept && (axil_req_i.awaddr == `VIS_ADDR_LEN);
  // Count is read-only but still answers OKAY
  assign wr_mapped = (axil_req_i.awaddr == `VIS_ADDR_CTRL)
                   || (axil_req_i.awaddr == `VIS_ADDR_LEN)
                   || (axil_req_i.awaddr == `VIS_ADDR_COUNT);

  // Byte-lane merge into the length register
  always_comb begin
    len_wr = int_len_q;
    if (axil_req_i.wstrb[0]) begin
      len_wr[7:0] = axil_req_i.wdata[7:0];
    end
    if (axil_req_i.wstrb[1]) begin
      len_wr[15:8] = axil_req_i.wdata[15:8];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      enable_q  <= 1'b0;
      int_len_q <= `VIS_LEN_BITS'(`VIS_LANES);
    end else begin
      if (wr_ctrl && axil_req_i.wstrb[0]) begin
        enable_q <= axil_req_i.wdata[0];
      end
      // Short lengths clamp so a batch drains before the next
      if (wr_len) begin
        int_len_q <= (len_wr < `VIS_LANES) ? `VIS_LEN_BITS'(`VIS_LANES) : len_wr;
      end
    end
  end

  // Output visibility counter, clear has priority
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (wr_ctrl && axil_req_i.wstrb[0] && axil_req_i.wdata[1]) begin
      count_q <= '0;
    end else if (vis_valid_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Write response, held until bready
  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid_q <= 1'b0;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp_q <= wr_mapped ? 2'b00 : 2'b10;
    end
  end

  // Read mux
  always_comb begin
    rd_mapped = 1'b1;
    case (axil_req_i.araddr)
      `VIS_ADDR_CTRL:  rd_data = {31'b0, enable_q};
      `VIS_ADDR_LEN:   rd_data = {{(32-`VIS_LEN_BITS){1'b0}}, int_len_q};
      `VIS_ADDR_COUNT: rd_data = count_q;
      default: begin
        rd_data   = '0;
        rd_mapped = 1'b0;
      end
    endcase
  end

  // Read response, held until rready
  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_mapped ? 2'b00 : 2'b10;
    end
  end

  // Ready strobes only in the accepting cycle
  always_comb begin
    axil_rsp_o.awready = wr_accept;
    axil_rsp_o.wready  = wr_accept;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = rd_accept;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign enable_o  = enable_q;
  assign int_len_o = int_len_q;

endmodule

//--- rtl/vis_consts.svh
`ifndef VIS_CONSTS_SVH
`define VIS_CONSTS_SVH

// Correlator lanes, also the merge chain length
`define VIS_LANES 4

// Signed width of each sample component
`define VIS_SAMPLE_BITS 4

// Signed width of each accumulator component
`define VIS_ACC_BITS 20

// Integration length register width
`define VIS_LEN_BITS 16

// AXI4-Lite register map, byte offsets
`define VIS_AXI_ADDR_BITS 4
`define VIS_ADDR_CTRL 4'h0
`define VIS_ADDR_LEN 4'h4
`define VIS_ADDR_COUNT 4'h8

`endif

//--- rtl/vis_corr_top.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

// Correlator front end: registers, lane MACs and merge chain
module vis_corr_top (
  input  logic                                   clock,
  input  logic                                   reset,

  // Register port
  input  vis_pkg::axil_req_t                     axil_req_i,
  output vis_pkg::axil_rsp_t                     axil_rsp_o,

  // Antenna sample pairs, one per lane
  input  logic                                   samples_valid_i,
  input  vis_pkg::sample_pair_t [`VIS_LANES-1:0] samples_i,

  // Serial visibility stream, no back-pressure
  output logic                                   vis_valid_o,
  output vis_pkg::vis_t                          vis_o
);

  logic                           enable;
  logic [`VIS_LEN_BITS-1:0]       int_len;
  logic [`VIS_LANES-1:0]          par_valid;
  vis_pkg::vis_t [`VIS_LANES-1:0] par_vis;

  // Control, length and output count
  vis_config_regs u_regs (
    .clock      (clock),
    .reset      (reset),
    .axil_req_i (axil_req_i),
    .vis_valid_i(vis_valid_o),
    .axil_rsp_o (axil_rsp_o),
    .enable_o   (enable),
    .int_len_o  (int_len)
  );

  // Per-lane conjugate multiply and integrate
  vis_correlator u_corr (
    .clock          (clock),
    .reset          (reset),
    .enable_i       (enable),
    .int_len_i      (int_len),
    .samples_valid_i(samples_valid_i),
    .samples_i      (samples_i),
    .par_valid_o    (par_valid),
    .par_vis_o      (par_vis)
  );

  // Parallel dump to serial stream, highest lane first
  vis_merge #(
    .payload_t(vis_pkg::vis_t),
    .length   (`VIS_LANES)
  ) u_merge (
    .clock      (clock),
    .reset      (reset),
    .par_valid_i(par_valid),
    .par_data_i (par_vis),
    .seq_valid_o(vis_valid_o),
    .seq_data_o (vis_o)
  );

endmodule

//--- rtl/vis_correlator.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

// Complex cross-multiply and integrate, one baseline per lane
module vis_correlator (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   enable_i,
  input  logic [`VIS_LEN_BITS-1:0]               int_len_i,
  input  logic                                   samples_valid_i,
  input  vis_pkg::sample_pair_t [`VIS_LANES-1:0] samples_i,
  output logic [`VIS_LANES-1:0]                  par_valid_o,
  output vis_pkg::vis_t [`VIS_LANES-1:0]         par_vis_o
);

  // Products already widened to accumulator size
  logic signed [`VIS_ACC_BITS-1:0] prod_re [`VIS_LANES];
  logic signed [`VIS_ACC_BITS-1:0] prod_im [`VIS_LANES];
  vis_pkg::vis_t [`VIS_LANES-1:0]  sum;
  vis_pkg::vis_t [`VIS_LANES-1:0]  acc_q;
  vis_pkg::vis_t [`VIS_LANES-1:0]  dump_q;
  logic [`VIS_LEN_BITS-1:0]        count_q;
  logic [`VIS_LEN_BITS-1:0]        count_next;
  logic                            accept;
  logic                            last;
  logic                            dump_valid_q;

  // a times conj(b), then running sum
  always_comb begin
    for (int ii = 0; ii < `VIS_LANES; ii++) begin
      prod_re[ii] = samples_i[ii].a.re * samples_i[ii].b.re
                  + samples_i[ii].a.im * samples_i[ii].b.im;
      prod_im[ii] = samples_i[ii].a.im * samples_i[ii].b.re
                  - samples_i[ii].a.re * samples_i[ii].b.im;
      sum[ii].re  = acc_q[ii].re + prod_re[ii];
      sum[ii].im  = acc_q[ii].im + prod_im[ii];
    end
  end

  // Shared sample counter for all lanes
  assign accept     = samples_valid_i & enable_i;
  assign count_next = count_q + 1'b1;
  assign last       = accept && (count_next == int_len_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      acc_q   <= '0;
    end else if (!enable_i) begin
      // Partial sums are thrown away while disabled
      count_q <= '0;
      acc_q   <= '0;
    end else if (accept) begin
      if (last) begin
        count_q <= '0;
        acc_q   <= '0;
      end else begin
        count_q <= count_next;
        acc_q   <= sum;
      end
    end
  end

  // Final sums include the last sample's product
  always_ff @(posedge clock) begin
    if (last) begin
      dump_q <= sum;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dump_valid_q <= 1'b0;
    end else begin
      dump_valid_q <= last;
    end
  end

  // Every lane dumps together
  assign par_valid_o = {`VIS_LANES{dump_valid_q}};
  assign par_vis_o   = dump_q;

endmodule

//--- rtl/vis_merge.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

// Daisy-chain that serialises one parallel batch per dump
// Highest-index element drives the output
module vis_merge #(
  parameter type payload_t = logic [7:0],
  parameter int  length    = `VIS_LANES
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [length-1:0]       par_valid_i,
  input  payload_t [length-1:0]   par_data_i,
  output logic                    seq_valid_o,
  output payload_t                seq_data_o
);

  logic [length-1:0]     valid_q;
  payload_t [length-1:0] data_q;
  logic [length-1:0]     src_valid;
  payload_t [length-1:0] src_data;

  // Upstream source for each element
  always_comb begin
    // Element 0 sees an empty, invalid neighbour
    src_valid[0] = 1'b0;
    src_data[0]  = '0;
    for (int ii = 1; ii < length; ii++) begin
      src_valid[ii] = valid_q[ii-1];
      src_data[ii]  = data_q[ii-1];
    end
  end

  // Element is full if it loads or forwards
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= par_valid_i | src_valid;
    end
  end

  // Registered 2:1 select per element
  always_ff @(posedge clock) begin
    for (int ii = 0; ii < length; ii++) begin
      if (par_valid_i[ii]) begin
        data_q[ii] <= par_data_i[ii];
      end else begin
        // Shift the in-flight batch one step downstream
        data_q[ii] <= src_data[ii];
      end
    end
  end

  assign seq_valid_o = valid_q[length-1];
  assign seq_data_o  = data_q[length-1];

endmodule

//--- rtl/vis_pkg.sv
`include "vis_consts.svh"

package vis_pkg;

  // One complex antenna sample
  typedef struct packed {
    logic signed [`VIS_SAMPLE_BITS-1:0] re;
    logic signed [`VIS_SAMPLE_BITS-1:0] im;
  } sample_t;

  // Both inputs of one baseline
  typedef struct packed {
    sample_t a;
    sample_t b;
  } sample_pair_t;

  // One integrated visibility
  typedef struct packed {
    logic signed [`VIS_ACC_BITS-1:0] re;
    logic signed [`VIS_ACC_BITS-1:0] im;
  } vis_t;

  // Master-driven AXI4-Lite channels
  typedef struct packed {
    logic                          awvalid;
    logic [`VIS_AXI_ADDR_BITS-1:0] awaddr;
    logic                          wvalid;
    logic [31:0]                   wdata;
    logic [3:0]                    wstrb;
    logic                          bready;
    logic                          arvalid;
    logic [`VIS_AXI_ADDR_BITS-1:0] araddr;
    logic                          rready;
  } axil_req_t;

  // Slave-driven AXI4-Lite channels
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

//--- verification/vis_corr_assert.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

// Protocol and datapath checks on the correlator top level
module vis_corr_assert (
  input logic                  clock,
  input logic                  reset,
  input vis_pkg::axil_req_t    req_i,
  input vis_pkg::axil_rsp_t    rsp_i,
  input logic [`VIS_LANES-1:0] par_valid_i,
  input logic                  vis_valid_i
);

  // Number of failed assertions, summed into the final result
  int fail_count = 0;

  // Write response held with a stable code until bready
  assert property (@(posedge clock) disable iff (reset)
    rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid && $stable(rsp_i.bresp))
  else begin
    $error("bvalid dropped or bresp changed before bready");
    fail_count++;
  end

  // Read response held with stable data until rready
  assert property (@(posedge clock) disable iff (reset)
    rsp_i.rvalid && !req_i.rready |=>
      rsp_i.rvalid && $stable(rsp_i.rdata) && $stable(rsp_i.rresp))
  else begin
    $error("rvalid dropped or read data changed before rready");
    fail_count++;
  end

  // Lanes dump together
  assert property (@(posedge clock) disable iff (reset)
    (par_valid_i == '0) || (&par_valid_i))
  else begin
    $error("par_valid bits differ between lanes");
    fail_count++;
  end

  // No output straight after a reset edge
  assert property (@(posedge clock) reset |=> !vis_valid_i)
  else begin
    $error("vis_valid high during reset");
    fail_count++;
  end

  // One stream beat per lane on the cycles after each dump
  for (genvar kk = 1; kk <= `VIS_LANES; kk++) begin : g_stream
    assert property (@(posedge clock) disable iff (reset)
      $past(par_valid_i[0], kk) |-> vis_valid_i)
    else begin
      $error("output stream shorter than the lane count after a dump");
      fail_count++;
    end
  end

endmodule

// Attached to every top level instance
bind vis_corr_top vis_corr_assert u_assert (
  .clock      (clock),
  .reset      (reset),
  .req_i      (axil_req_i),
  .rsp_i      (axil_rsp_o),
  .par_valid_i(par_valid),
  .vis_valid_i(vis_valid_o)
);

//--- verification/vis_corr_tb.sv
`timescale 1ns/100ps
`include "vis_consts.svh"

module vis_corr_tb;

  // About 26 register accesses of up to 6 cycles, then sample bursts and drains
  localparam int axi_cycles    = 26 * 6;
  localparam int sample_cycles = 8 + 5 * `VIS_LANES + 3 + 8 + 4;
  localparam int drain_cycles  = 3 * (3 * `VIS_LANES);
  localparam int cycle_limit   = 5 + axi_cycles + sample_cycles + drain_cycles + 100;

  logic                                   clock = 1'b0;
  logic                                   reset;
  vis_pkg::axil_req_t                     axil_req;
  vis_pkg::axil_rsp_t                     axil_rsp;
  logic                                   samples_valid;
  vis_pkg::sample_pair_t [`VIS_LANES-1:0] samples;
  logic                                   vis_valid;
  vis_pkg::vis_t                          vis;

  // Reference model sums per lane
  int            acc_re [`VIS_LANES];
  int            acc_im [`VIS_LANES];
  int            model_len;
  int            model_cnt;
  // Expected and observed stream of the running test
  vis_pkg::vis_t exp_q [$];
  vis_pkg::vis_t got_q [$];
  int            got_cyc [$];
  int            cycle_cnt = 0;
  // Visibilities the model has predicted over the whole run
  int            total_vis = 0;
  int            err_cnt = 0;
  int            test_err = 0;
  int            test_cnt = 0;
  int            check_cnt = 0;

  always #2 clock = ~clock;

  vis_corr_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .axil_req_i     (axil_req),
    .axil_rsp_o     (axil_rsp),
    .samples_valid_i(samples_valid),
    .samples_i      (samples),
    .vis_valid_o    (vis_valid),
    .vis_o          (vis)
  );

  // Run limit
  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not complete within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  // Capture the serial stream away from the driving edge
  always @(negedge clock) begin
    if (!reset && vis_valid) begin
      got_q.push_back(vis);
      got_cyc.push_back(cycle_cnt);
    end
  end

  task automatic compare_vis(input vis_pkg::vis_t expected, input vis_pkg::vis_t actual,
                             input string what);
    check_cnt++;
    if (actual !== expected) begin
      $display("MISMATCH %0t: %s expected re %0d im %0d, got re %0d im %0d", $time, what,
               expected.re, expected.im, actual.re, actual.im);
      test_err++;
    end
  endtask

  task automatic compare_word(input logic [31:0] expected, input logic [31:0] actual,
                              input string what);
    check_cnt++;
    if (actual !== expected) begin
      $display("MISMATCH %0t: %s expected 0x%08h, got 0x%08h", $time, what, expected, actual);
      test_err++;
    end
  endtask

  task automatic compare_resp(input logic [1:0] expected, input logic [1:0] actual,
                              input string what);
    check_cnt++;
    if (actual !== expected) begin
      $display("MISMATCH %0t: %s response expected %b, got %b", $time, what, expected, actual);
      test_err++;
    end
  endtask

  // Address and data together, then wait for the response
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    @(posedge clock);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.bready  <= 1'b1;
    do @(negedge clock); while (!axil_rsp.awready);
    @(posedge clock);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do @(negedge clock); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge clock);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clock);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    do @(negedge clock); while (!axil_rsp.arready);
    @(posedge clock);
    axil_req.arvalid <= 1'b0;
    do @(negedge clock); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clock);
    axil_req.rready <= 1'b0;
  endtask

  task automatic write_check(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp,
                             input string what);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    compare_resp(exp_resp, resp, what);
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp_data,
                            input string what);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    compare_resp(2'b00, resp, what);
    compare_word(exp_data, data, what);
  endtask

  task automatic model_clear();
    model_cnt = 0;
    for (int ii = 0; ii < `VIS_LANES; ii++) begin
      acc_re[ii] = 0;
      acc_im[ii] = 0;
    end
  endtask

  // a times conj(b) summed per lane, dumped highest lane first
  task automatic model_sample(input vis_pkg::sample_pair_t [`VIS_LANES-1:0] pairs);
    vis_pkg::vis_t v;
    int            ar;
    int            ai;
    int            br;
    int            bi;
    for (int ii = 0; ii < `VIS_LANES; ii++) begin
      ar = $signed(pairs[ii].a.re);
      ai = $signed(pairs[ii].a.im);
      br = $signed(pairs[ii].b.re);
      bi = $signed(pairs[ii].b.im);
      acc_re[ii] += ar * br + ai * bi;
      acc_im[ii] += ai * br - ar * bi;
    end
    model_cnt++;
    if (model_cnt == model_len) begin
      for (int ii = `VIS_LANES - 1; ii >= 0; ii--) begin
        v.re = `VIS_ACC_BITS'(acc_re[ii]);
        v.im = `VIS_ACC_BITS'(acc_im[ii]);
        exp_q.push_back(v);
        total_vis++;
      end
      model_clear();
    end
  endtask

  // One sample pair per lane on each of n cycles, then idle
  task automatic drive_samples(input int n, input bit use_random);
    vis_pkg::sample_pair_t [`VIS_LANES-1:0] pairs;
    for (int k = 0; k < n; k++) begin
      for (int ii = 0; ii < `VIS_LANES; ii++) begin
        if (use_random) begin
          pairs[ii] = 16'($urandom);
        end else begin
          // Fixed sweep over signs and magnitudes
          pairs[ii] = 16'(k * 'h1357 + ii * 'h2d1f + 'h9c37);
        end
      end
      @(posedge clock);
      samples_valid <= 1'b1;
      samples       <= pairs;
      model_sample(pairs);
    end
    @(posedge clock);
    samples_valid <= 1'b0;
  endtask

  // Wait for the expected beats, allow time for extras, then compare
  task automatic check_stream(input string what, input bit contiguous);
    int n;
    n = exp_q.size();
    while (got_q.size() < n) @(negedge clock);
    repeat (2 * `VIS_LANES) @(negedge clock);
    check_cnt++;
    if (got_q.size() != n) begin
      $display("%s: expected %0d visibilities but received %0d", what, n, got_q.size());
      test_err++;
    end
    for (int ii = 0; ii < n && ii < got_q.size(); ii++) begin
      compare_vis(exp_q[ii], got_q[ii], what);
      if (contiguous && ii > 0 && got_cyc[ii] != got_cyc[ii-1] + 1) begin
        $display("%s: output stream has a gap before visibility %0d", what, ii);
        test_err++;
      end
    end
  endtask

  task automatic start_test();
    test_err = 0;
    exp_q.delete();
    got_q.delete();
    got_cyc.delete();
  endtask

  task automatic report_test(input string name);
    $display("[%0t] %s: %s, %0d errors", $time, name, (test_err == 0) ? "ok" : "FAILED",
             test_err);
    err_cnt += test_err;
    test_cnt++;
  endtask

  task automatic test_register_reset();
    start_test();
    read_check(`VIS_ADDR_CTRL, 32'd0, "ctrl after reset");
    read_check(`VIS_ADDR_LEN, `VIS_LANES, "length after reset");
    read_check(`VIS_ADDR_COUNT, 32'd0, "count after reset");
    write_check(`VIS_ADDR_LEN, 32'd8, 4'hf, 2'b00, "length write");
    read_check(`VIS_ADDR_LEN, 32'd8, "length readback");
    // Only byte 0 strobed, upper byte keeps its old zero
    write_check(`VIS_ADDR_LEN, 32'h1234, 4'h1, 2'b00, "length byte write");
    read_check(`VIS_ADDR_LEN, 32'h34, "length byte readback");
    write_check(`VIS_ADDR_LEN, 32'd2, 4'hf, 2'b00, "short length write");
    read_check(`VIS_ADDR_LEN, `VIS_LANES, "short length clamped");
    write_check(`VIS_ADDR_CTRL, 32'd1, 4'hf, 2'b00, "ctrl write");
    read_check(`VIS_ADDR_CTRL, 32'd1, "ctrl readback");
    write_check(`VIS_ADDR_CTRL, 32'd0, 4'hf, 2'b00, "ctrl clear");
    report_test("register reset and readback");
  endtask

  task automatic test_unmapped_access();
    logic [31:0] data;
    logic [1:0]  resp;
    start_test();
    axi_read(4'hc, data, resp);
    compare_resp(2'b10, resp, "unmapped read");
    write_check(4'hc, 32'h5a5a, 4'hf, 2'b10, "unmapped write");
    write_check(`VIS_ADDR_COUNT, 32'h77, 4'hf, 2'b00, "count write");
    read_check(`VIS_ADDR_COUNT, total_vis, "count after write");
    report_test("unmapped and read-only access");
  endtask

  task automatic test_single_integration();
    start_test();
    write_check(`VIS_ADDR_LEN, 32'd8, 4'hf, 2'b00, "length 8");
    write_check(`VIS_ADDR_CTRL, 32'd1, 4'hf, 2'b00, "enable");
    model_len = 8;
    model_clear();
    drive_samples(8, 1'b0);
    check_stream("single integration", 1'b1);
    report_test("single integration");
  endtask

  task automatic test_back_to_back();
    start_test();
    write_check(`VIS_ADDR_LEN, `VIS_LANES, 4'hf, 2'b00, "length lanes");
    model_len = `VIS_LANES;
    model_clear();
    // Five batches with no idle cycle between them
    drive_samples(5 * `VIS_LANES, 1'b1);
    check_stream("back-to-back", 1'b1);
    report_test("back-to-back integrations");
  endtask

  task automatic test_disable_midway();
    start_test();
    write_check(`VIS_ADDR_LEN, 32'd8, 4'hf, 2'b00, "length 8");
    model_len = 8;
    model_clear();
    drive_samples(3, 1'b1);
    write_check(`VIS_ADDR_CTRL, 32'd0, 4'hf, 2'b00, "disable");
    // Partial sums are gone in the DUT too
    model_clear();
    write_check(`VIS_ADDR_CTRL, 32'd1, 4'hf, 2'b00, "re-enable");
    drive_samples(8, 1'b1);
    check_stream("disable mid-integration", 1'b1);
    report_test("disable mid-integration");
  endtask

  task automatic test_output_count();
    start_test();
    read_check(`VIS_ADDR_COUNT, total_vis, "count of observed visibilities");
    // Bit 1 clears the count, bit 0 low disables
    write_check(`VIS_ADDR_CTRL, 32'd2, 4'hf, 2'b00, "count clear");
    read_check(`VIS_ADDR_COUNT, 32'd0, "count after clear");
    report_test("output count and clear");
  endtask

  initial begin
    void'($urandom(32'h161));
    reset         = 1'b1;
    axil_req      = '0;
    samples_valid = 1'b0;
    samples       = '0;
    model_len     = `VIS_LANES;
    model_clear();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    test_register_reset();
    test_unmapped_access();
    test_single_integration();
    test_back_to_back();
    test_disable_midway();
    test_output_count();
    err_cnt += i_dut.u_assert.fail_count;
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vis_corr.f
+incdir+rtl
rtl/vis_pkg.sv
rtl/vis_config_regs.sv
rtl/vis_correlator.sv
rtl/vis_merge.sv
rtl/vis_corr_top.sv
verification/vis_corr_assert.sv
verification/vis_corr_tb.sv
